// ==== source/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// core-wide sizing, shared by rtl and bench

`define CPU_XLEN     32              // machine word width
`define CPU_NREGS    32              // architectural registers, x0 included

`define CPU_RESET_PC 32'h0000_0000   // first fetch address
`define CPU_NOP      32'h0000_0013   // addi x0, x0, 0

`endif

// ==== source/isa_pkg.sv ====
`default_nettype none
`include "cpu_macros.svh"

package isa_pkg;

    typedef logic [`CPU_XLEN-1:0]          word_t;       // data, address, instr
    typedef logic [$clog2(`CPU_NREGS)-1:0] reg_idx_t;    // rs1/rs2/rd field
    typedef logic [2:0]                    funct3_t;
    typedef logic [6:0]                    funct7_t;
    typedef logic [3:0]                    alu_flags_t;  // {n, z, c, v}

    localparam int FLAG_N = 3;             // result negative
    localparam int FLAG_Z = 2;             // result zero
    localparam int FLAG_C = 1;             // carry out of adder
    localparam int FLAG_V = 0;             // signed overflow

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    localparam funct3_t F3_ADD_SUB = 3'b000;   // alu group
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_BEQ     = 3'b000;   // branch group
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_BLT     = 3'b100;
    localparam funct3_t F3_BGE     = 3'b101;
    localparam funct3_t F3_WORD    = 3'b010;   // lw / sw width
    localparam funct3_t F3_JALR    = 3'b000;

    localparam funct7_t F7_BASE    = 7'b0000000;
    localparam funct7_t F7_ALT     = 7'b0100000;   // sub, sra

endpackage

`default_nettype wire

// ==== source/ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    typedef enum logic [2:0] {
        IMM_I,                  // loads, op-imm, jalr
        IMM_S,                  // stores
        IMM_B,                  // branches, bit 0 implied zero
        IMM_J,                  // jal
        IMM_U                   // lui, auipc
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,                // also used to compare for branches
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,                // signed less than
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_EXT_IMM,
        ALU_SRC_PC
    } alu_src_e;

    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_PC_PLUS_4,      // link value for jal / jalr
        RES_SRC_EXT_IMM,        // lui
        RES_SRC_MEM             // lw
    } res_src_e;

    typedef enum logic [1:0] {
        PC_SRC_PLUS_4,
        PC_SRC_PLUS_OFF,        // taken branch, jal
        PC_SRC_REG_PLUS_OFF     // jalr
    } pc_src_e;

endpackage

`default_nettype wire

// ==== source/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module regfile import isa_pkg::*; (
    input  wire           clk,
    input  wire reg_idx_t rd_addr1,     // rs1
    input  wire reg_idx_t rd_addr2,     // rs2
    input  wire reg_idx_t wr_addr,      // rd
    input  wire word_t    wr_data,
    input  wire           we,
    output word_t         rd_data1,
    output word_t         rd_data2
);
    word_t regs [`CPU_NREGS];           // x0 slot never written

    always_ff @(posedge clk) begin
        if (we && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;   // writes to x0 dropped here
        end
    end

    // combinational reads, x0 forced to zero
    assign rd_data1 = (rd_addr1 == '0) ? '0 : regs[rd_addr1];
    assign rd_data2 = (rd_addr2 == '0) ? '0 : regs[rd_addr2];

endmodule

`default_nettype wire

// ==== source/extend.sv ====
`timescale 1ns/1ps
`default_nettype none

module extend import isa_pkg::*; import ctrl_pkg::*; (
    input  wire word_t    instr,
    input  wire imm_src_e imm_src,
    output word_t         ext_imm
);
    logic sign;                         // instr[31] is the sign for every format

    assign sign = instr[31];

    always_comb begin
        case (imm_src)
            IMM_I:   ext_imm = {{20{sign}}, instr[31:20]};
            IMM_S:   ext_imm = {{20{sign}}, instr[31:25], instr[11:7]};
            IMM_B:   ext_imm = {{19{sign}}, instr[31], instr[7],
                                instr[30:25], instr[11:8], 1'b0};     // 13 bit offset
            IMM_J:   ext_imm = {{11{sign}}, instr[31], instr[19:12],
                                instr[20], instr[30:21], 1'b0};       // 21 bit offset
            IMM_U:   ext_imm = {instr[31:12], 12'b0};                 // low bits zero
            default: ext_imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module alu import isa_pkg::*; import ctrl_pkg::*; (
    input  wire word_t   op_a,
    input  wire word_t   op_b,
    input  wire alu_op_e alu_ctrl,
    output word_t        alu_out,
    output alu_flags_t   alu_flags
);
    localparam int SHAMT_W = $clog2(`CPU_XLEN);

    logic               subtract;       // sub and slt share the adder
    word_t              addend_b;       // op_b or its inverse
    logic [`CPU_XLEN:0] sum;            // extra bit for carry out
    logic               carry;
    logic               overflow;
    logic               less;           // signed op_a < op_b
    logic [SHAMT_W-1:0] shamt;

    assign subtract = (alu_ctrl == ALU_SUB) || (alu_ctrl == ALU_SLT);
    assign addend_b = subtract ? ~op_b : op_b;
    assign sum      = {1'b0, op_a} + {1'b0, addend_b} + {{`CPU_XLEN{1'b0}}, subtract};
    assign carry    = sum[`CPU_XLEN];
    assign overflow = (op_a[`CPU_XLEN-1] == addend_b[`CPU_XLEN-1])
                   && (sum[`CPU_XLEN-1] != op_a[`CPU_XLEN-1]);  // like signs, sign flipped
    assign less     = sum[`CPU_XLEN-1] ^ overflow;
    assign shamt    = op_b[SHAMT_W-1:0];  // only low 5 bits shift

    always_comb begin
        case (alu_ctrl)
            ALU_AND: alu_out = op_a & op_b;
            ALU_OR:  alu_out = op_a | op_b;
            ALU_XOR: alu_out = op_a ^ op_b;
            ALU_SLT: alu_out = {{(`CPU_XLEN-1){1'b0}}, less};
            ALU_SLL: alu_out = op_a << shamt;
            ALU_SRL: alu_out = op_a >> shamt;
            ALU_SRA: alu_out = $signed(op_a) >>> shamt;   // sign fill
            default: alu_out = sum[`CPU_XLEN-1:0];        // add, sub
        endcase
    end

    always_comb begin
        alu_flags         = '0;
        alu_flags[FLAG_N] = alu_out[`CPU_XLEN-1];
        alu_flags[FLAG_Z] = (alu_out == '0);
        alu_flags[FLAG_C] = carry;       // from adder path only
        alu_flags[FLAG_V] = overflow;
    end

endmodule

`default_nettype wire

// ==== source/datapath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module datapath import isa_pkg::*; import ctrl_pkg::*; (
    input  wire           clk,
    input  wire           rst_n,
    input  wire word_t    instr,
    input  wire word_t    read_data,    // load data, same cycle
    input  wire           reg_we,
    input  wire imm_src_e imm_src,
    input  wire alu_op_e  alu_ctrl,
    input  wire alu_src_e alu_src_a,
    input  wire alu_src_e alu_src_b,
    input  wire res_src_e result_src,
    input  wire pc_src_e  pc_src,
    output word_t         pc,
    output word_t         alu_out,      // doubles as data address
    output alu_flags_t    alu_flags,
    output word_t         write_data
);
    word_t pc_plus_4;
    word_t pc_plus_off;
    word_t pc_reg_plus_off;
    word_t pc_next;
    word_t reg_rd1;                     // rs1 value
    word_t reg_rd2;                     // rs2 value
    word_t reg_wr_data;
    word_t ext_imm;
    word_t alu_op_a;
    word_t alu_op_b;

    // one selector serves both alu operands
    function automatic word_t pick_operand(alu_src_e sel, word_t rs1, word_t rs2,
                                           word_t imm, word_t pc_val);
        word_t res;
        case (sel)
            ALU_SRC_REG_1:   res = rs1;
            ALU_SRC_REG_2:   res = rs2;
            ALU_SRC_EXT_IMM: res = imm;
            default:         res = pc_val;      // ALU_SRC_PC
        endcase
        return res;
    endfunction

    assign pc_plus_4       = pc + 32'd4;
    assign pc_plus_off     = pc + ext_imm;                  // branch, jal target
    assign pc_reg_plus_off = reg_rd1 + ext_imm;             // jalr target before bit 0 clear

    always_comb begin
        case (pc_src)
            PC_SRC_PLUS_OFF:     pc_next = pc_plus_off;
            PC_SRC_REG_PLUS_OFF: pc_next = {pc_reg_plus_off[`CPU_XLEN-1:1], 1'b0};
            default:             pc_next = pc_plus_4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `CPU_RESET_PC;
        end else begin
            pc <= pc_next;              // one instruction per edge
        end
    end

    always_comb begin
        case (result_src)
            RES_SRC_PC_PLUS_4: reg_wr_data = pc_plus_4;     // link
            RES_SRC_EXT_IMM:   reg_wr_data = ext_imm;
            RES_SRC_MEM:       reg_wr_data = read_data;
            default:           reg_wr_data = alu_out;
        endcase
    end

    regfile u_regfile (
        .clk      (clk),
        .rd_addr1 (instr[19:15]),
        .rd_addr2 (instr[24:20]),
        .wr_addr  (instr[11:7]),
        .wr_data  (reg_wr_data),
        .we       (reg_we),
        .rd_data1 (reg_rd1),
        .rd_data2 (reg_rd2)
    );

    assign write_data = reg_rd2;        // store data is always rs2

    extend u_extend (
        .instr   (instr),
        .imm_src (imm_src),
        .ext_imm (ext_imm)
    );

    assign alu_op_a = pick_operand(alu_src_a, reg_rd1, reg_rd2, ext_imm, pc);
    assign alu_op_b = pick_operand(alu_src_b, reg_rd1, reg_rd2, ext_imm, pc);

    alu u_alu (
        .op_a      (alu_op_a),
        .op_b      (alu_op_b),
        .alu_ctrl  (alu_ctrl),
        .alu_out   (alu_out),
        .alu_flags (alu_flags)
    );

endmodule

`default_nettype wire

// ==== source/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit import isa_pkg::*; import ctrl_pkg::*; (
    input  wire             rst_n,
    input  wire word_t      instr,
    input  wire alu_flags_t alu_flags,  // from rs1 - rs2 on branches
    output logic            reg_we,
    output logic            mem_we,
    output imm_src_e        imm_src,
    output alu_op_e         alu_ctrl,
    output alu_src_e        alu_src_a,
    output alu_src_e        alu_src_b,
    output res_src_e        result_src,
    output pc_src_e         pc_src
);
    opcode_e opcode;
    funct3_t funct3;
    funct7_t funct7;
    logic    is_reg;                    // r-type, funct7 matters
    logic    f7_base;
    logic    f7_alt;
    alu_op_e arith_op;
    logic    arith_ok;                  // legal op / op-imm encoding
    logic    signed_lt;
    logic    take_branch;
    logic    reg_we_dec;
    logic    mem_we_dec;

    assign opcode    = opcode_e'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7    = instr[31:25];
    assign is_reg    = (opcode == OP_REG);
    assign f7_base   = (funct7 == F7_BASE);
    assign f7_alt    = (funct7 == F7_ALT);
    assign signed_lt = alu_flags[FLAG_N] ^ alu_flags[FLAG_V];

    always_comb begin
        arith_op = ALU_ADD;
        arith_ok = 1'b0;
        case (funct3)
            F3_ADD_SUB: begin
                arith_op = (is_reg && f7_alt) ? ALU_SUB : ALU_ADD;
                arith_ok = !is_reg || f7_base || f7_alt;
            end
            F3_SLT: begin arith_op = ALU_SLT; arith_ok = !is_reg || f7_base; end
            F3_XOR: begin arith_op = ALU_XOR; arith_ok = !is_reg || f7_base; end
            F3_OR:  begin arith_op = ALU_OR;  arith_ok = !is_reg || f7_base; end
            F3_AND: begin arith_op = ALU_AND; arith_ok = !is_reg || f7_base; end
            F3_SLL: begin arith_op = ALU_SLL; arith_ok = is_reg && f7_base; end   // no slli
            F3_SRL_SRA: begin
                arith_op = f7_alt ? ALU_SRA : ALU_SRL;
                arith_ok = is_reg && (f7_base || f7_alt);
            end
            default: arith_ok = 1'b0;   // sltu and the like
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  take_branch = alu_flags[FLAG_Z];
            F3_BNE:  take_branch = !alu_flags[FLAG_Z];
            F3_BLT:  take_branch = signed_lt;
            F3_BGE:  take_branch = !signed_lt;
            default: take_branch = 1'b0;        // unsigned branches fall through
        endcase
    end

    always_comb begin
        reg_we_dec = 1'b0;              // defaults decode as a no-op
        mem_we_dec = 1'b0;
        imm_src    = IMM_I;
        alu_ctrl   = ALU_ADD;
        alu_src_a  = ALU_SRC_REG_1;
        alu_src_b  = ALU_SRC_EXT_IMM;
        result_src = RES_SRC_ALU_OUT;
        pc_src     = PC_SRC_PLUS_4;
        case (opcode)
            OP_LUI: begin
                imm_src    = IMM_U;
                result_src = RES_SRC_EXT_IMM;
                reg_we_dec = 1'b1;
            end
            OP_AUIPC: begin
                imm_src    = IMM_U;
                alu_src_a  = ALU_SRC_PC;        // pc + upper imm
                reg_we_dec = 1'b1;
            end
            OP_JAL: begin
                imm_src    = IMM_J;
                result_src = RES_SRC_PC_PLUS_4;
                pc_src     = PC_SRC_PLUS_OFF;
                reg_we_dec = 1'b1;
            end
            OP_JALR: begin
                if (funct3 == F3_JALR) begin
                    result_src = RES_SRC_PC_PLUS_4;
                    pc_src     = PC_SRC_REG_PLUS_OFF;
                    reg_we_dec = 1'b1;
                end
            end
            OP_BRANCH: begin
                imm_src   = IMM_B;
                alu_ctrl  = ALU_SUB;            // flags from rs1 - rs2
                alu_src_b = ALU_SRC_REG_2;
                pc_src    = take_branch ? PC_SRC_PLUS_OFF : PC_SRC_PLUS_4;
            end
            OP_LOAD: begin
                result_src = RES_SRC_MEM;
                reg_we_dec = (funct3 == F3_WORD);   // lw only
            end
            OP_STORE: begin
                imm_src    = IMM_S;
                mem_we_dec = (funct3 == F3_WORD);   // sw only
            end
            OP_IMM: begin
                alu_ctrl   = arith_op;
                reg_we_dec = arith_ok;
            end
            OP_REG: begin
                alu_ctrl   = arith_op;
                alu_src_b  = ALU_SRC_REG_2;
                reg_we_dec = arith_ok;
            end
            default: begin
            end
        endcase
    end

    assign reg_we = reg_we_dec && rst_n;    // nothing commits during reset
    assign mem_we = mem_we_dec && rst_n;

endmodule

`default_nettype wire

// ==== source/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top import isa_pkg::*; import ctrl_pkg::*; (
    input  wire        clk,
    input  wire        rst_n,
    input  wire word_t instr,           // fetched at pc, same cycle
    input  wire word_t read_data,       // load data for mem_addr
    output word_t      pc,
    output word_t      mem_addr,
    output word_t      write_data,
    output logic       mem_we           // store commits at the edge
);
    logic       reg_we;
    imm_src_e   imm_src;
    alu_op_e    alu_ctrl;
    alu_src_e   alu_src_a;
    alu_src_e   alu_src_b;
    res_src_e   result_src;
    pc_src_e    pc_src;
    alu_flags_t alu_flags;              // back to branch resolution

    control_unit u_ctrl (
        .rst_n      (rst_n),
        .instr      (instr),
        .alu_flags  (alu_flags),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .result_src (result_src),
        .pc_src     (pc_src)
    );

    datapath u_dp (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .reg_we     (reg_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src_a  (alu_src_a),
        .alu_src_b  (alu_src_b),
        .result_src (result_src),
        .pc_src     (pc_src),
        .pc         (pc),
        .alu_out    (mem_addr),         // alu result is the data address
        .alu_flags  (alu_flags),
        .write_data (write_data)
    );

endmodule

`default_nettype wire

// ==== bench/tb_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module tb_cpu import isa_pkg::*; ();
    localparam int RESET_CYCLES = 10;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_LEN [NUM_TESTS] = '{16, 60, 40, 100, 20, 400};  // cycles run per test

    logic  clk;
    logic  rst_n;
    word_t instr;
    word_t read_data;
    word_t pc;
    word_t mem_addr;
    word_t write_data;
    logic  mem_we;

    word_t imem [256];                  // program words indexed by pc[9:2]
    word_t dmem [256];                  // written by the dut
    word_t sdmem [256];                 // shadow copy for the model
    word_t sreg [32];                   // shadow register file
    word_t spc;                         // shadow pc

    integer seed;
    int     prog_len;
    int     err_count;
    int     errs_before;
    int     pass_count;
    int     fail_count;
    int     cycles;
    int     cycle_limit;
    int     rst_low;                    // negedges seen with rst_n low
    logic   checking;
    string  test_name [NUM_TESTS];

    word_t  chk_instr;                  // checker working values
    word_t  exp_pc;
    logic   exp_we;
    word_t  exp_addr;
    word_t  exp_data;

    cpu_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .pc         (pc),
        .mem_addr   (mem_addr),
        .write_data (write_data),
        .mem_we     (mem_we)
    );

    assign instr     = imem[pc[9:2]];   // same-cycle fetch
    assign read_data = dmem[mem_addr[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;         // 100 ns period
    end

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[9:2]] <= write_data;
        end
    end

    function automatic int rnd(input int n);
        return ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    function automatic word_t fill_word(input int idx);
        word_t a;
        a = word_t'(idx * 4);           // byte address of the word
        return (a * 32'h9e37_79b1) ^ 32'h5a3c_c3a5;
    endfunction

    // instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], OP_STORE};  // base x0
    endfunction

    function automatic word_t enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // ISA model of one instruction on the shadow state
    function automatic void ref_step(input word_t ins, output word_t npc, output logic st_we,
                                     output word_t st_addr, output word_t st_data);
        logic [2:0] f3;
        logic [6:0] f7;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      res;
        logic       wr;
        logic       take;
        f3      = ins[14:12];
        f7      = ins[31:25];
        a       = sreg[ins[19:15]];
        b       = sreg[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        npc     = spc + 32'd4;
        st_we   = 1'b0;
        st_addr = '0;
        st_data = '0;
        res     = '0;
        wr      = 1'b0;
        take    = 1'b0;
        case (ins[6:0])
            OP_LUI: begin
                res = {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            OP_AUIPC: begin
                res = spc + {ins[31:12], 12'b0};
                wr  = 1'b1;
            end
            OP_JAL: begin
                res = spc + 32'd4;
                npc = spc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                wr  = 1'b1;
            end
            OP_JALR: if (f3 == 3'd0) begin
                res = spc + 32'd4;
                npc = (a + imm_i) & ~32'd1;         // target bit 0 dropped
                wr  = 1'b1;
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0:    take = (a == b);
                    3'd1:    take = (a != b);
                    3'd4:    take = ($signed(a) < $signed(b));
                    3'd5:    take = ($signed(a) >= $signed(b));
                    default: take = 1'b0;
                endcase
                if (take) begin
                    npc = spc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            OP_LOAD: if (f3 == 3'd2) begin
                st_addr = a + imm_i;
                res     = sdmem[st_addr[9:2]];
                st_addr = '0;
                wr      = 1'b1;
            end
            OP_STORE: if (f3 == 3'd2) begin
                st_we   = 1'b1;
                st_addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                st_data = b;
                sdmem[st_addr[9:2]] = b;
            end
            OP_IMM: begin
                wr = 1'b1;
                case (f3)
                    3'd0:    res = a + imm_i;
                    3'd2:    res = {31'b0, $signed(a) < $signed(imm_i)};
                    3'd4:    res = a ^ imm_i;
                    3'd6:    res = a | imm_i;
                    3'd7:    res = a & imm_i;
                    default: wr = 1'b0;         // no shift-immediates here
                endcase
            end
            OP_REG: begin
                wr = 1'b1;
                case ({f7, f3})
                    {7'h00, 3'd0}: res = a + b;
                    {7'h20, 3'd0}: res = a - b;
                    {7'h00, 3'd1}: res = a << b[4:0];
                    {7'h00, 3'd2}: res = {31'b0, $signed(a) < $signed(b)};
                    {7'h00, 3'd4}: res = a ^ b;
                    {7'h00, 3'd5}: res = a >> b[4:0];
                    {7'h20, 3'd5}: res = $signed(a) >>> b[4:0];
                    {7'h00, 3'd6}: res = a | b;
                    {7'h00, 3'd7}: res = a & b;
                    default:       wr = 1'b0;
                endcase
            end
            default: wr = 1'b0;                 // unknown opcode is a no-op
        endcase
        if (wr && ins[11:7] != 5'd0) begin
            sreg[ins[11:7]] = res;
        end
    endfunction

    task automatic put(input word_t w);
        imem[8'(prog_len)] = w;
        prog_len = prog_len + 1;
    endtask

    task automatic store_reg(input reg_idx_t r, input int slot);
        put(enc_s(12'(slot * 4), r));
    endtask

    task automatic set_reg(input reg_idx_t r, input word_t v);
        word_t up;
        up = v + 32'h800;               // addi below sign-extends
        put({up[31:12], r, OP_LUI});
        put(enc_i(v[11:0], r, 3'd0, r, OP_IMM));
    endtask

    task automatic gen_alu(output reg_idx_t rd);
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] f3;
        int         k;
        rd  = reg_idx_t'(rnd(8));       // x0 included so writes get dropped
        rs1 = reg_idx_t'(1 + rnd(7));
        rs2 = reg_idx_t'(1 + rnd(7));
        k   = rnd(14);
        case (k)
            0, 5:    f3 = 3'd0;
            1, 7:    f3 = 3'd7;
            2, 8:    f3 = 3'd6;
            3, 9:    f3 = 3'd4;
            4, 10:   f3 = 3'd2;
            11:      f3 = 3'd1;
            default: f3 = 3'd5;         // srl, sra
        endcase
        if (k < 5) begin
            put(enc_i(12'($random(seed)), rs1, f3, rd, OP_IMM));
        end else if (k == 6) begin
            put(enc_r(7'h20, rs2, rs1, 3'd0, rd));          // sub
        end else if (k == 13) begin
            put(enc_r(7'h20, rs2, rs1, 3'd5, rd));          // sra
        end else begin
            put(enc_r(7'h00, rs2, rs1, f3, rd));
        end
    endtask

    task automatic build_program(input int t);
        reg_idx_t   rd;
        reg_idx_t   r2;
        word_t      pa [5];
        word_t      pb [5];
        logic [2:0] bf3 [4];
        int         p;
        pa  = '{32'd5, -32'sd3, 32'd9, 32'h7fff_ffff, 32'h8000_0000};
        pb  = '{32'd5, 32'd9, -32'sd3, 32'h8000_0000, 32'h7fff_ffff};
        bf3 = '{3'd0, 3'd1, 3'd4, 3'd5};
        prog_len = 0;
        for (int i = 0; i < 256; i++) imem[i] = `CPU_NOP;
        case (t)
            0: begin
                store_reg(5'd0, 0);     // fetched all through reset, store held off
                for (int r = 1; r < 8; r++) begin
                    set_reg(reg_idx_t'(r), word_t'($random(seed)));
                end
            end
            1: begin
                repeat (24) begin
                    gen_alu(rd);
                    store_reg(rd, rnd(64));
                end
                put(enc_i(12'd5, 5'd1, 3'd0, 5'd0, OP_IMM));   // addi x0 must not stick
                store_reg(5'd0, 0);
            end
            2: begin
                repeat (6) begin
                    rd = reg_idx_t'(1 + rnd(7));
                    r2 = reg_idx_t'(1 + rnd(7));
                    p  = rnd(64);
                    set_reg(rd, word_t'($random(seed)));
                    store_reg(rd, p);
                    put(enc_i(12'(p * 4), 5'd0, 3'd2, r2, OP_LOAD));
                    store_reg(r2, 64 + rnd(64));    // loaded value back out
                end
                put({20'($random(seed)), 5'd4, OP_LUI});
                store_reg(5'd4, 130);
                put({20'($random(seed)), 5'd4, OP_AUIPC});
                store_reg(5'd4, 131);
            end
            3: for (int k = 0; k < 5; k++) begin
                set_reg(5'd1, pa[k]);
                set_reg(5'd2, pb[k]);
                for (int j = 0; j < 4; j++) begin
                    put(enc_b(13'd8, 5'd2, 5'd1, bf3[j]));      // skips the increment
                    put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OP_IMM));
                    store_reg(5'd7, rnd(64));
                end
            end
            4: begin
                put(enc_j(21'd8, 5'd3));
                put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OP_IMM));    // jumped over
                store_reg(5'd3, 10);                            // link value
                p = prog_len;
                put(enc_i(12'((p + 3) * 4 + 1), 5'd0, 3'd0, 5'd5, OP_IMM));  // odd target
                put(enc_i(12'd0, 5'd5, 3'd0, 5'd6, OP_JALR));
                put(enc_i(12'd1, 5'd7, 3'd0, 5'd7, OP_IMM));
                store_reg(5'd6, 11);
            end
            default: while (prog_len < 256) begin
                rd = reg_idx_t'(rnd(8));
                r2 = reg_idx_t'(1 + rnd(7));
                p  = rnd(10);
                case (p)
                    0, 1, 2: gen_alu(rd);
                    3: put(enc_i(12'(rnd(256) * 4), 5'd0, 3'd2, rd, OP_LOAD));
                    4: store_reg(r2, rnd(256));
                    5: put(enc_b(13'((1 + rnd(6)) * (rnd(2) ? 4 : -4)), r2,
                                 reg_idx_t'(1 + rnd(7)), bf3[rnd(4)]));
                    6: put(enc_j(21'((1 + rnd(16)) * (rnd(2) ? 4 : -4)), rd));
                    7: put(enc_i(12'(rnd(256) * 4), 5'd0, 3'd0, rd, OP_JALR));
                    8: put({20'($random(seed)), rd, rnd(2) ? OP_LUI : OP_AUIPC});
                    default: put({25'($random(seed)), 7'b0001011});  // not decoded
                endcase
            end
        endcase
    endtask

    // lockstep compare at the falling edge where outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            rst_low = rst_low + 1;
            if (rst_low >= 2 && (pc !== `CPU_RESET_PC || mem_we !== 1'b0)) begin
                $display("ERR %0t: in reset pc %h mem_we %b", $time, pc, mem_we);
                err_count = err_count + 1;
            end
        end else begin
            rst_low = 0;
            if (checking) begin
                chk_instr = imem[spc[9:2]];
                ref_step(chk_instr, exp_pc, exp_we, exp_addr, exp_data);
                if (pc !== spc) begin
                    $display("ERR %0t: pc %h expected %h", $time, pc, spc);
                    err_count = err_count + 1;
                end
                if (mem_we !== exp_we) begin
                    $display("ERR %0t: mem_we %b expected %b at pc %h", $time, mem_we,
                             exp_we, spc);
                    err_count = err_count + 1;
                end else if (exp_we && (mem_addr !== exp_addr || write_data !== exp_data)) begin
                    $display("ERR %0t: store %h <- %h expected %h <- %h", $time, mem_addr,
                             write_data, exp_addr, exp_data);
                    err_count = err_count + 1;
                end
                spc = exp_pc;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        seed        = 32'h62a68796;
        rst_n       = 1'b0;             // reset from time zero
        checking    = 1'b0;
        err_count   = 0;
        pass_count  = 0;
        fail_count  = 0;
        cycles      = 0;
        rst_low     = 0;
        spc         = `CPU_RESET_PC;
        cycle_limit = 0;
        test_name   = '{"reset", "alu", "memory", "branch", "jump", "random"};
        for (int i = 0; i < NUM_TESTS; i++) cycle_limit += TEST_LEN[i] + RESET_CYCLES + 2;
        cycle_limit = cycle_limit + cycle_limit / 10;   // margin
        for (int i = 0; i < 32; i++) sreg[i] = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]  = fill_word(i);
            sdmem[i] = fill_word(i);
            imem[i]  = `CPU_NOP;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            @(negedge clk);             // write enables gated so reload is safe
            errs_before = err_count;    // reset-phase mismatches belong to this test
            build_program(t);
            repeat (RESET_CYCLES) @(posedge clk);
            rst_n       <= 1'b1;
            spc         = `CPU_RESET_PC;
            checking    = 1'b1;
            repeat (TEST_LEN[t]) @(posedge clk);
            rst_n    <= 1'b0;           // last checked commit lands on this edge
            checking = 1'b0;
            if (err_count == errs_before) begin
                pass_count = pass_count + 1;
                $display("test %s passed", test_name[t]);
            end else begin
                fail_count = fail_count + 1;
                $display("test %s failed with %0d mismatches", test_name[t],
                         err_count - errs_before);
            end
        end
        @(negedge clk);
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/isa_pkg.sv
source/ctrl_pkg.sv
source/regfile.sv
source/extend.sv
source/alu.sv
source/datapath.sv
source/control_unit.sv
source/cpu_top.sv
bench/tb_cpu.sv

// ==== Makefile ====
.PHONY: compile run clean

compile:
	verilator --binary -f sources.f --top-module tb_cpu -o tb_cpu

run: compile
	out="$$(./obj_dir/tb_cpu)"; echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
